//--- design/icache_config.svh
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// cache geometry, two ways of 64 sets
`define ICACHE_SETS 64
`define ICACHE_INDEX_W 6
`define ICACHE_TAG_W 23
`define ICACHE_OFFSET_W 3

// datapath widths
`define ICACHE_WORD_W 32
`define ICACHE_LINE_W 64

// byte address on the refill port
`define ICACHE_MEM_ADDR_W 32

// tag + index + offset must cover a full fetch address
// 23 + 6 + 3 = 32

`endif

//--- design/icache_addr_pkg.sv
`default_nettype none

`include "icache_config.svh"

package icache_addr_pkg;

    // fields of a fetch address
    typedef logic [`ICACHE_TAG_W-1:0] tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;

    // only bit 2 selects the word, bits 1:0 ignored
    typedef logic [`ICACHE_OFFSET_W-1:0] offset_t;

    // line address on the refill port
    // {tag, index, 3'b000}
    typedef logic [`ICACHE_MEM_ADDR_W-1:0] mem_addr_t;

endpackage

`default_nettype wire

//--- design/icache_line_pkg.sv
`default_nettype none

`include "icache_config.svh"

package icache_line_pkg;

    typedef logic [`ICACHE_WORD_W-1:0] word_t;

    // word 0 in the low half
    typedef logic [`ICACHE_LINE_W-1:0] line_t;

    typedef logic way_t;

    // one bit per way, bit 0 is way 0
    typedef logic [1:0] way_vec_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_REQ,
        MISS_RELEASE,
        REFILL
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- design/icache_tag_array.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_config.svh"

module icache_tag_array
    import icache_addr_pkg::*, icache_line_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire index_t   rd_index,
    output tag_t          rd_tag0,
    output tag_t          rd_tag1,
    output way_vec_t      rd_valid,
    output way_t          rd_lru,
    input  wire logic     touch_en,
    input  wire index_t   touch_index,
    input  wire way_t     touch_way,
    input  wire logic     wr_en,
    input  wire index_t   wr_index,
    input  wire way_t     wr_way,
    input  wire tag_t     wr_tag
);

    tag_t tag0_mem [0:`ICACHE_SETS-1];
    tag_t tag1_mem [0:`ICACHE_SETS-1];

    logic [`ICACHE_SETS-1:0] valid0;
    logic [`ICACHE_SETS-1:0] valid1;
    // lru[set] names the least recently used way
    logic [`ICACHE_SETS-1:0] lru;

    always_ff @(posedge clk) begin
        if (wr_en && !wr_way) begin
            tag0_mem[wr_index] <= wr_tag;
        end
        if (wr_en && wr_way) begin
            tag1_mem[wr_index] <= wr_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid0 <= '0;
            valid1 <= '0;
            lru    <= '0;
        end else if (wr_en) begin
            valid0[wr_index] <= valid0[wr_index] | !wr_way;
            valid1[wr_index] <= valid1[wr_index] | wr_way;
            lru[wr_index]    <= !wr_way;
        end else if (touch_en) begin
            lru[touch_index] <= !touch_way;
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        rd_tag0  <= tag0_mem[rd_index];
        rd_tag1  <= tag1_mem[rd_index];
        rd_valid <= {valid1[rd_index], valid0[rd_index]};
        rd_lru   <= lru[rd_index];
    end

endmodule

`default_nettype wire

//--- design/icache_data_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_config.svh"

module icache_data_ram
    import icache_addr_pkg::*, icache_line_pkg::*;
(
    input  wire logic   clk,
    input  wire index_t rd_index,
    output line_t       rd_line0,
    output line_t       rd_line1,
    input  wire logic   wr_en,
    input  wire index_t wr_index,
    input  wire way_t   wr_way,
    input  wire line_t  wr_line
);

    // both ways side by side, one row per set
    line_t line0_mem [0:`ICACHE_SETS-1];
    line_t line1_mem [0:`ICACHE_SETS-1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (wr_way) begin
                line1_mem[wr_index] <= wr_line;
            end else begin
                line0_mem[wr_index] <= wr_line;
            end
        end
    end

    // synchronous read, contents valid one cycle later
    always_ff @(posedge clk) begin
        rd_line0 <= line0_mem[rd_index];
        rd_line1 <= line1_mem[rd_index];
    end

endmodule

`default_nettype wire

//--- design/icache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_config.svh"

module icache_ctrl
    import icache_addr_pkg::*, icache_line_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,

    // fetch side
    input  wire logic     valid,
    input  wire index_t   index,
    input  wire tag_t     tag,
    input  wire offset_t  offset,
    output logic          addr_ok,
    output logic          data_ok,
    output word_t         rdata,

    // refill side
    output logic          mem_req,
    output mem_addr_t     mem_addr,
    input  wire logic     mem_ack,
    input  wire line_t    mem_rdata,

    // array read
    output index_t        rd_index,
    input  wire tag_t     rd_tag0,
    input  wire tag_t     rd_tag1,
    input  wire way_vec_t rd_valid,
    input  wire way_t     rd_lru,
    input  wire line_t    rd_line0,
    input  wire line_t    rd_line1,

    // array update
    output logic          touch_en,
    output index_t        touch_index,
    output way_t          touch_way,
    output logic          wr_en,
    output index_t        wr_index,
    output way_t          wr_way,
    output tag_t          wr_tag,
    output line_t         wr_line
);

    ctrl_state_t state;
    ctrl_state_t next_state;

    tag_t    req_tag;
    index_t  req_index;
    offset_t req_offset;

    logic  accept;
    logic  hit0;
    logic  hit1;
    logic  hit;
    way_t  victim;
    way_t  victim_way;
    line_t hit_line;
    line_t refill_line;

    function automatic word_t word_sel(input line_t line, input logic upper);
        word_t word;
        if (upper) begin
            word = line[`ICACHE_LINE_W-1:`ICACHE_WORD_W];
        end else begin
            word = line[`ICACHE_WORD_W-1:0];
        end
        return word;
    endfunction

    assign addr_ok = (state == IDLE);
    assign accept  = valid && addr_ok;

    // request buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            req_tag    <= tag;
            req_index  <= index;
            req_offset <= offset;
        end
    end

    // index from the port while idle, buffered index afterwards
    assign rd_index = (state == IDLE) ? index : req_index;

    // tag compare
    assign hit0 = rd_valid[0] && (rd_tag0 == req_tag);
    assign hit1 = rd_valid[1] && (rd_tag1 == req_tag);
    assign hit  = hit0 || hit1;

    assign hit_line = hit1 ? rd_line1 : rd_line0;

    // invalid way first, way 0 before way 1, else the lru way
    always_comb begin
        if (!rd_valid[0]) begin
            victim = 1'b0;
        end else if (!rd_valid[1]) begin
            victim = 1'b1;
        end else begin
            victim = rd_lru;
        end
    end

    always_ff @(posedge clk) begin
        if (state == LOOKUP) begin
            victim_way <= victim;
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            IDLE: begin
                if (accept) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                // hold off the request until memory is quiet
                if (hit) begin
                    next_state = IDLE;
                end else if (!mem_ack) begin
                    next_state = MISS_REQ;
                end
            end
            MISS_REQ: begin
                if (mem_ack) begin
                    next_state = MISS_RELEASE;
                end
            end
            MISS_RELEASE: begin
                if (!mem_ack) begin
                    next_state = REFILL;
                end
            end
            REFILL: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // refill handshake
    assign mem_req  = (state == MISS_REQ);
    assign mem_addr = {req_tag, req_index, {`ICACHE_OFFSET_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (state == MISS_REQ && mem_ack) begin
            refill_line <= mem_rdata;
        end
    end

    // response, bit 2 of the offset picks the word
    assign data_ok = ((state == LOOKUP) && hit) || (state == REFILL);
    assign rdata   = (state == REFILL) ? word_sel(refill_line, req_offset[2])
                                       : word_sel(hit_line, req_offset[2]);

    assign touch_en    = (state == LOOKUP) && hit;
    assign touch_index = req_index;
    assign touch_way   = hit1;

    assign wr_en    = (state == REFILL);
    assign wr_index = req_index;
    assign wr_way   = victim_way;
    assign wr_tag   = req_tag;
    assign wr_line  = refill_line;

endmodule

`default_nettype wire

//--- design/icache_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_config.svh"

module icache_top
    import icache_addr_pkg::*, icache_line_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,

    input  wire logic    valid,
    input  wire index_t  index,
    input  wire tag_t    tag,
    input  wire offset_t offset,
    output logic         addr_ok,
    output logic         data_ok,
    output word_t        rdata,

    output logic         mem_req,
    output mem_addr_t    mem_addr,
    input  wire logic    mem_ack,
    input  wire line_t   mem_rdata
);

    index_t   rd_index;
    tag_t     rd_tag0;
    tag_t     rd_tag1;
    way_vec_t rd_valid;
    way_t     rd_lru;
    line_t    rd_line0;
    line_t    rd_line1;

    logic     touch_en;
    index_t   touch_index;
    way_t     touch_way;

    logic     wr_en;
    index_t   wr_index;
    way_t     wr_way;
    tag_t     wr_tag;
    line_t    wr_line;

    icache_ctrl ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .valid       (valid),
        .index       (index),
        .tag         (tag),
        .offset      (offset),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .rd_index    (rd_index),
        .rd_tag0     (rd_tag0),
        .rd_tag1     (rd_tag1),
        .rd_valid    (rd_valid),
        .rd_lru      (rd_lru),
        .rd_line0    (rd_line0),
        .rd_line1    (rd_line1),
        .touch_en    (touch_en),
        .touch_index (touch_index),
        .touch_way   (touch_way),
        .wr_en       (wr_en),
        .wr_index    (wr_index),
        .wr_way      (wr_way),
        .wr_tag      (wr_tag),
        .wr_line     (wr_line)
    );

    icache_tag_array tag_array_i (
        .clk         (clk),
        .rst         (rst),
        .rd_index    (rd_index),
        .rd_tag0     (rd_tag0),
        .rd_tag1     (rd_tag1),
        .rd_valid    (rd_valid),
        .rd_lru      (rd_lru),
        .touch_en    (touch_en),
        .touch_index (touch_index),
        .touch_way   (touch_way),
        .wr_en       (wr_en),
        .wr_index    (wr_index),
        .wr_way      (wr_way),
        .wr_tag      (wr_tag)
    );

    // line storage, no reset
    icache_data_ram data_ram_i (
        .clk      (clk),
        .rd_index (rd_index),
        .rd_line0 (rd_line0),
        .rd_line1 (rd_line1),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_way   (wr_way),
        .wr_line  (wr_line)
    );

endmodule

`default_nettype wire

//--- verification/icache_props.sv
`timescale 1ns/10ps
`default_nettype none

module icache_props
    import icache_addr_pkg::*;
(
    input wire logic      clk,
    input wire logic      rst,
    input wire logic      addr_ok,
    input wire logic      data_ok,
    input wire logic      mem_req,
    input wire mem_addr_t mem_addr,
    input wire logic      mem_ack
);

    // a pending fetch blocks new requests
    fetch_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(addr_ok && data_ok))
        else $error("addr_ok and data_ok high in the same cycle");

    // request held with a steady address until memory answers
    req_held: assert property (@(posedge clk) disable iff (rst)
        (mem_req && !mem_ack) |=> (mem_req && $stable(mem_addr)))
        else $error("mem_req dropped or mem_addr moved before mem_ack");

    // ack must already be low in the cycle the request is raised from
    req_after_release: assert property (@(posedge clk) disable iff (rst)
        $rose(mem_req) |-> !$past(mem_ack))
        else $error("mem_req raised while mem_ack still high");

    req_low_after_reset: assert property (@(posedge clk)
        rst |=> !mem_req)
        else $error("mem_req high right after reset");

endmodule

bind icache_top icache_props props_i (
    .clk      (clk),
    .rst      (rst),
    .addr_ok  (addr_ok),
    .data_ok  (data_ok),
    .mem_req  (mem_req),
    .mem_addr (mem_addr),
    .mem_ack  (mem_ack)
);

`default_nettype wire

//--- verification/icache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module icache_tb
    import icache_addr_pkg::*, icache_line_pkg::*;
();

    localparam int NUM_FETCHES    = 22;
    localparam int TIMEOUT_CYCLES = 50;

    typedef struct packed {
        logic [31:0] addr;
        logic        exp_hit;
        logic        do_reset;
    } fetch_entry_t;

    typedef enum logic [1:0] {
        RSP_IDLE,
        RSP_DELAY,
        RSP_ACK
    } rsp_state_t;

    logic      clk;
    logic      rst;
    logic      valid;
    index_t    index;
    tag_t      tag;
    offset_t   offset;
    logic      addr_ok;
    logic      data_ok;
    word_t     rdata;
    logic      mem_req;
    mem_addr_t mem_addr;
    logic      mem_ack;
    line_t     mem_rdata;

    fetch_entry_t fetch_tab [0:NUM_FETCHES-1];
    logic [7:0]   lfsr;
    int           refill_count;
    mem_addr_t    last_req_addr;

    icache_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // taps 8,6,5,4
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic stop_with_failure();
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        rst   = 1'b1;
        valid = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (addr_ok && !data_ok && !mem_req) else begin
            $display("MISMATCH at %0t: addr_ok=%b data_ok=%b mem_req=%b after reset",
                     $time, addr_ok, data_ok, mem_req);
            stop_with_failure();
        end
    endtask

    // set 5 holds tags 0x123, 0x456 and 0x789, set 63 holds tag 0x5a5a5a
    task automatic load_fetch_table();
        fetch_tab[0]  = '{32'h0002_4628, 1'b0, 1'b0};
        fetch_tab[1]  = '{32'h0002_462C, 1'b1, 1'b0};
        fetch_tab[2]  = '{32'h0002_462F, 1'b1, 1'b0};
        fetch_tab[3]  = '{32'h0008_AC28, 1'b0, 1'b0};
        fetch_tab[4]  = '{32'h0002_4628, 1'b1, 1'b0};
        fetch_tab[5]  = '{32'h0008_AC2C, 1'b1, 1'b0};
        fetch_tab[6]  = '{32'h0002_462C, 1'b1, 1'b0};
        fetch_tab[7]  = '{32'h0008_AC28, 1'b1, 1'b0};
        fetch_tab[8]  = '{32'h0002_4628, 1'b1, 1'b0};
        // B is lru now, so C takes way 1
        fetch_tab[9]  = '{32'h000F_1228, 1'b0, 1'b0};
        fetch_tab[10] = '{32'h0002_4628, 1'b1, 1'b0};
        fetch_tab[11] = '{32'h0008_AC28, 1'b0, 1'b0};
        fetch_tab[12] = '{32'h0002_462C, 1'b1, 1'b0};
        fetch_tab[13] = '{32'h000F_122C, 1'b0, 1'b0};
        fetch_tab[14] = '{32'hB4B4_B5F8, 1'b0, 1'b0};
        fetch_tab[15] = '{32'hB4B4_B5FC, 1'b1, 1'b0};
        // everything cold again
        fetch_tab[16] = '{32'h0002_4628, 1'b0, 1'b1};
        fetch_tab[17] = '{32'hB4B4_B5FC, 1'b0, 1'b0};
        fetch_tab[18] = '{32'h0002_462C, 1'b1, 1'b0};
        fetch_tab[19] = '{32'h000F_1228, 1'b0, 1'b0};
        fetch_tab[20] = '{32'h0002_4628, 1'b1, 1'b0};
        fetch_tab[21] = '{32'h000F_122C, 1'b1, 1'b0};
    endtask

    task automatic run_fetch(input int n);
        logic [31:0] addr;
        logic        exp_hit;
        word_t       exp_word;
        int          refills_before;
        int          wait_cycles;
        int          latency;
        addr           = fetch_tab[n].addr;
        exp_hit        = fetch_tab[n].exp_hit;
        // memory holds the inverted byte address of each word
        exp_word       = ~{addr[31:2], 2'b00};
        refills_before = refill_count;
        valid  = 1'b1;
        tag    = addr[31:9];
        index  = addr[8:3];
        offset = addr[2:0];
        wait_cycles = 0;
        while (!addr_ok) begin
            next_cycle();
            wait_cycles++;
            assert (wait_cycles <= TIMEOUT_CYCLES) else begin
                $display("timeout: entry %0d was never accepted", n);
                stop_with_failure();
            end
        end
        next_cycle();
        valid   = 1'b0;
        latency = 1;
        while (!data_ok) begin
            next_cycle();
            latency++;
            assert (latency <= TIMEOUT_CYCLES) else begin
                $display("timeout: no data_ok for entry %0d", n);
                stop_with_failure();
            end
        end
        assert (exp_hit ? (latency == 1) : (latency > 1)) else begin
            $display("MISMATCH at %0t: entry %0d expected hit=%b, data_ok after %0d cycles",
                     $time, n, exp_hit, latency);
            stop_with_failure();
        end
        assert ((refill_count - refills_before) == (exp_hit ? 0 : 1)) else begin
            $display("MISMATCH at %0t: entry %0d made %0d refills, expected hit=%b",
                     $time, n, refill_count - refills_before, exp_hit);
            stop_with_failure();
        end
        assert (exp_hit || (last_req_addr == {addr[31:3], 3'b000})) else begin
            $display("MISMATCH at %0t: entry %0d refill address %h, expected %h",
                     $time, n, last_req_addr, {addr[31:3], 3'b000});
            stop_with_failure();
        end
        assert (rdata == exp_word) else begin
            $display("MISMATCH at %0t: entry %0d rdata %h, expected %h",
                     $time, n, rdata, exp_word);
            stop_with_failure();
        end
        next_cycle();
        assert (!data_ok && addr_ok) else begin
            $display("MISMATCH at %0t: entry %0d data_ok=%b addr_ok=%b after the response",
                     $time, n, data_ok, addr_ok);
            stop_with_failure();
        end
    endtask

    // four-phase memory with a random delay of 0 to 3 cycles before mem_ack
    initial begin : mem_responder
        rsp_state_t rsp_state;
        int         delay_left;
        int         ack_cycles;
        logic [1:0] delay_bits;
        mem_addr_t  base;
        mem_ack       = 1'b0;
        mem_rdata     = '0;
        lfsr          = 8'd83;
        refill_count  = 0;
        last_req_addr = '0;
        rsp_state     = RSP_IDLE;
        delay_left    = 0;
        ack_cycles    = 0;
        base          = '0;
        forever begin
            next_cycle();
            if (rst) begin
                rsp_state = RSP_IDLE;
                mem_ack   = 1'b0;
            end else begin
                case (rsp_state)
                    RSP_IDLE: begin
                        if (mem_req) begin
                            refill_count++;
                            last_req_addr = mem_addr;
                            base          = mem_addr;
                            assert (mem_addr[2:0] == 3'b000) else begin
                                $display("MISMATCH at %0t: refill address %h not line aligned",
                                         $time, mem_addr);
                                stop_with_failure();
                            end
                            lfsr          = lfsr_step(lfsr);
                            delay_bits[0] = lfsr[0];
                            lfsr          = lfsr_step(lfsr);
                            delay_bits[1] = lfsr[0];
                            delay_left    = int'(delay_bits);
                            rsp_state     = RSP_DELAY;
                        end
                    end
                    RSP_DELAY: begin
                        delay_left--;
                    end
                    RSP_ACK: begin
                        if (!mem_req) begin
                            mem_ack   = 1'b0;
                            rsp_state = RSP_IDLE;
                        end else begin
                            ack_cycles++;
                            assert (ack_cycles <= TIMEOUT_CYCLES) else begin
                                $display("timeout: mem_req never dropped after mem_ack");
                                stop_with_failure();
                            end
                        end
                    end
                    default: begin
                        rsp_state = RSP_IDLE;
                    end
                endcase
                if (rsp_state == RSP_DELAY && delay_left <= 0) begin
                    mem_rdata  = {~(base + 32'd4), ~base};
                    mem_ack    = 1'b1;
                    ack_cycles = 0;
                    rsp_state  = RSP_ACK;
                end
            end
        end
    end

    initial begin
        rst    = 1'b1;
        valid  = 1'b0;
        index  = '0;
        tag    = '0;
        offset = '0;
        load_fetch_table();
        apply_reset();
        for (int i = 0; i < NUM_FETCHES; i++) begin
            if (fetch_tab[i].do_reset) begin
                apply_reset();
            end
            run_fetch(i);
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+design
design/icache_addr_pkg.sv
design/icache_line_pkg.sv
design/icache_tag_array.sv
design/icache_data_ram.sv
design/icache_ctrl.sv
design/icache_top.sv
verification/icache_props.sv
verification/icache_tb.sv

//--- Makefile
VERILATOR := verilator
TOP       := icache_tb
FLIST     := flist.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/10ps
LINTFLAGS := --lint-only --timing --assert --timescale 1ns/10ps
PASS_MSG  := sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

# the run passes only if the pass line shows up in the output
run: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)
